// ==== source/exu_pkg.sv ====
package exu_pkg;

    // ==============================
    // widths
    // ==============================
    localparam int xlen    = 64;
    localparam int aluop_w = 4;
    localparam int bcuop_w = 3;

    // alu operation codes
    localparam logic [aluop_w-1:0] alu_add   = 4'd0;
    localparam logic [aluop_w-1:0] alu_sub   = 4'd1;
    localparam logic [aluop_w-1:0] alu_sll   = 4'd2;
    localparam logic [aluop_w-1:0] alu_slt   = 4'd3;
    localparam logic [aluop_w-1:0] alu_sltu  = 4'd4;
    localparam logic [aluop_w-1:0] alu_xor   = 4'd5;
    localparam logic [aluop_w-1:0] alu_srl   = 4'd6;
    localparam logic [aluop_w-1:0] alu_sra   = 4'd7;
    localparam logic [aluop_w-1:0] alu_or    = 4'd8;
    localparam logic [aluop_w-1:0] alu_and   = 4'd9;
    localparam logic [aluop_w-1:0] alu_auipc = 4'd10;
    localparam logic [aluop_w-1:0] alu_lui   = 4'd11; // op2 straight through
    localparam logic [aluop_w-1:0] alu_jalr  = 4'd12;

    // branch operation codes
    localparam logic [bcuop_w-1:0] bcu_none = 3'd0;
    localparam logic [bcuop_w-1:0] bcu_beq  = 3'd1;
    localparam logic [bcuop_w-1:0] bcu_bne  = 3'd2;
    localparam logic [bcuop_w-1:0] bcu_blt  = 3'd3;
    localparam logic [bcuop_w-1:0] bcu_bge  = 3'd4;
    localparam logic [bcuop_w-1:0] bcu_bltu = 3'd5;
    localparam logic [bcuop_w-1:0] bcu_bgeu = 3'd6;
    localparam logic [bcuop_w-1:0] bcu_jal  = 3'd7;

    // major opcodes
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_imm32  = 7'b0011011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_reg32  = 7'b0111011;

    // second operand select
    localparam logic [1:0] sel_reg    = 2'd0;
    localparam logic [1:0] sel_offset = 2'd1;

    // ==============================
    // instruction formats
    // ==============================
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_t;

endpackage

// ==== source/idu.sv ====
module idu import exu_pkg::*; (
    input  logic [31:0]        inst,
    output logic [aluop_w-1:0] aluop,
    output logic [bcuop_w-1:0] bcuop,
    output logic [xlen-1:0]    offset,
    output logic [1:0]         sl,
    output logic               wordop
);

    inst_t w;

    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;

    assign w = inst;

    // ==============================
    // immediates, sign extended
    // ==============================
    assign imm_i = {{52{w.i.imm[11]}}, w.i.imm};
    assign imm_s = {{52{w.s.imm_hi[6]}}, w.s.imm_hi, w.s.imm_lo};
    assign imm_b = {{51{w.b.imm12}}, w.b.imm12, w.b.imm11, w.b.imm10_5, w.b.imm4_1, 1'b0};
    assign imm_u = {{44{w.u.imm[19]}}, w.u.imm}; // unshifted, exu does the << 12
    assign imm_j = {{43{w.j.imm20}}, w.j.imm20, w.j.imm19_12, w.j.imm11, w.j.imm10_1, 1'b0};

    always_comb begin
        // no-op: rs1 + 0
        aluop  = alu_add;
        bcuop  = bcu_none;
        offset = '0;
        sl     = sel_offset;
        wordop = 1'b0;

        case (w.r.opcode)
            op_lui: begin
                aluop  = alu_lui;
                offset = imm_u;
            end
            op_auipc: begin
                aluop  = alu_auipc;
                offset = imm_u;
            end
            op_jal: begin
                bcuop  = bcu_jal;
                offset = imm_j;
            end
            op_jalr: begin
                aluop  = alu_jalr;
                offset = imm_i;
            end
            op_branch: begin
                aluop  = alu_sub; // flags only
                sl     = sel_reg;
                offset = imm_b;
                case (w.b.funct3)
                    3'b000:  bcuop = bcu_beq;
                    3'b001:  bcuop = bcu_bne;
                    3'b100:  bcuop = bcu_blt;
                    3'b101:  bcuop = bcu_bge;
                    3'b110:  bcuop = bcu_bltu;
                    3'b111:  bcuop = bcu_bgeu;
                    default: bcuop = bcu_none;
                endcase
            end
            op_load:  offset = imm_i;
            op_store: offset = imm_s;
            op_imm, op_reg: begin
                if (w.r.opcode == op_reg) begin
                    sl = sel_reg;
                end else begin
                    offset = imm_i;
                end
                case (w.r.funct3)
                    3'b000: begin
                        // subtract only in the register form
                        aluop = (w.r.opcode == op_reg && w.r.funct7[5]) ? alu_sub : alu_add;
                    end
                    3'b001:  aluop = alu_sll;
                    3'b010:  aluop = alu_slt;
                    3'b011:  aluop = alu_sltu;
                    3'b100:  aluop = alu_xor;
                    3'b101:  aluop = w.r.funct7[5] ? alu_sra : alu_srl;
                    3'b110:  aluop = alu_or;
                    default: aluop = alu_and;
                endcase
            end
            op_imm32: begin
                if (w.i.funct3 == 3'b000) begin // addiw
                    offset = imm_i;
                    wordop = 1'b1;
                end
            end
            op_reg32: begin
                if (w.r.funct3 == 3'b000) begin // addw / subw
                    aluop  = w.r.funct7[5] ? alu_sub : alu_add;
                    sl     = sel_reg;
                    wordop = 1'b1;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== source/alu.sv ====
module alu import exu_pkg::*; (
    input  logic [aluop_w-1:0] aluop,
    input  logic [xlen-1:0]    op1,
    input  logic [xlen-1:0]    op2,
    output logic [xlen-1:0]    result,
    output logic               lt,
    output logic               ltu,
    output logic               zero
);

    logic [xlen-1:0] diff;
    logic            borrow;
    logic [5:0]      shamt;

    // ==============================
    // compare flags
    // ==============================
    assign {borrow, diff} = {1'b0, op1} - {1'b0, op2};

    assign zero = (diff == '0);
    assign ltu  = borrow;
    // signs differ: op1 negative means less
    assign lt   = (op1[xlen-1] != op2[xlen-1]) ? op1[xlen-1] : diff[xlen-1];

    assign shamt = op2[5:0];

    always_comb begin
        case (aluop)
            alu_add:   result = op1 + op2;
            alu_sub:   result = diff;
            alu_sll:   result = op1 << shamt;
            alu_slt:   result = {{(xlen-1){1'b0}}, lt};
            alu_sltu:  result = {{(xlen-1){1'b0}}, ltu};
            alu_xor:   result = op1 ^ op2;
            alu_srl:   result = op1 >> shamt;
            alu_sra:   result = $unsigned($signed(op1) >>> shamt);
            alu_or:    result = op1 | op2;
            alu_and:   result = op1 & op2;
            alu_auipc,
            alu_lui:   result = op2;
            alu_jalr:  result = op1 + op2; // target before bit 0 clear
            default:   result = op1 + op2;
        endcase
    end

endmodule

// ==== source/bcu.sv ====
module bcu import exu_pkg::*; (
    input  logic               lt,
    input  logic               ltu,
    input  logic               zero,
    input  logic [bcuop_w-1:0] bcuop,
    input  logic [xlen-1:0]    pc,
    input  logic [xlen-1:0]    offset,
    output logic               jump_branch,
    output logic [xlen-1:0]    dnpc
);

    logic taken;

    always_comb begin
        case (bcuop)
            bcu_beq:  taken = zero;
            bcu_bne:  taken = ~zero;
            bcu_blt:  taken = lt;
            bcu_bge:  taken = ~lt;
            bcu_bltu: taken = ltu;
            bcu_bgeu: taken = ~ltu;
            bcu_jal:  taken = 1'b1;
            default:  taken = 1'b0;
        endcase
    end

    assign jump_branch = taken;

    // fall through to the next word when not taken
    assign dnpc = taken ? (pc + offset) : (pc + 64'd4);

endmodule

// ==== source/exu.sv ====
module exu import exu_pkg::*; (
    input  logic [aluop_w-1:0] aluop,
    input  logic [bcuop_w-1:0] bcuop,
    input  logic [xlen-1:0]    op1,
    input  logic [xlen-1:0]    op2,
    input  logic [xlen-1:0]    pc,
    input  logic [xlen-1:0]    offset,
    input  logic [1:0]         sl,
    input  logic               wordop,
    output logic               jump_branch,
    output logic [xlen-1:0]    result,
    output logic [xlen-1:0]    dnpc,
    output logic [xlen-1:0]    mdata
);

    logic            lt;
    logic            ltu;
    logic            zero;
    logic            bcu_taken;
    logic [xlen-1:0] alu_op2;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] bcu_dnpc;
    logic [xlen-1:0] adder_op1;
    logic [xlen-1:0] adder_op2;
    logic [xlen-1:0] adder_result;
    logic            auipc_op;
    logic            lui_op;
    logic            jal_op;
    logic            jalr_op;

    assign alu_op2 = (sl == sel_offset) ? offset : op2;

    alu u_alu (
        .aluop  (aluop),
        .op1    (op1),
        .op2    (alu_op2),
        .result (alu_result),
        .lt     (lt),
        .ltu    (ltu),
        .zero   (zero)
    );

    bcu u_bcu (
        .lt          (lt),
        .ltu         (ltu),
        .zero        (zero),
        .bcuop       (bcuop),
        .pc          (pc),
        .offset      (offset),
        .jump_branch (bcu_taken),
        .dnpc        (bcu_dnpc)
    );

    assign auipc_op = (aluop == alu_auipc);
    assign lui_op   = (aluop == alu_lui);
    assign jal_op   = (bcuop == bcu_jal);
    assign jalr_op  = (aluop == alu_jalr);

    // ==============================
    // link / upper adder
    // ==============================
    assign adder_op1    = lui_op ? '0 : pc;
    assign adder_op2    = (auipc_op | lui_op) ? (alu_result << 12) :
                          (jal_op | jalr_op)  ? 64'd4 : '0;
    assign adder_result = adder_op1 + adder_op2;

    assign jump_branch = bcu_taken | jalr_op;
    assign dnpc        = jalr_op ? {alu_result[xlen-1:1], 1'b0} : bcu_dnpc;
    assign result      = (auipc_op | lui_op | jal_op | jalr_op) ? adder_result :
                         wordop ? {{32{alu_result[31]}}, alu_result[31:0]} : alu_result;
    assign mdata       = op2; // store data is rs2 as read

endmodule

// ==== source/ex_top.sv ====
module ex_top import exu_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            in_valid,
    input  logic [31:0]     inst,
    input  logic [xlen-1:0] pc,
    input  logic [xlen-1:0] rs1_data,
    input  logic [xlen-1:0] rs2_data,
    output logic            out_valid,
    output logic            jump_branch,
    output logic [xlen-1:0] result,
    output logic [xlen-1:0] dnpc,
    output logic [xlen-1:0] mdata
);

    logic [aluop_w-1:0] aluop;
    logic [bcuop_w-1:0] bcuop;
    logic [xlen-1:0]    offset;
    logic [1:0]         sl;
    logic               wordop;
    logic               ex_jump_branch;
    logic [xlen-1:0]    ex_result;
    logic [xlen-1:0]    ex_dnpc;
    logic [xlen-1:0]    ex_mdata;

    idu u_idu (
        .inst   (inst),
        .aluop  (aluop),
        .bcuop  (bcuop),
        .offset (offset),
        .sl     (sl),
        .wordop (wordop)
    );

    exu u_exu (
        .aluop       (aluop),
        .bcuop       (bcuop),
        .op1         (rs1_data),
        .op2         (rs2_data),
        .pc          (pc),
        .offset      (offset),
        .sl          (sl),
        .wordop      (wordop),
        .jump_branch (ex_jump_branch),
        .result      (ex_result),
        .dnpc        (ex_dnpc),
        .mdata       (ex_mdata)
    );

    // ==============================
    // output stage
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid   <= 1'b0;
            jump_branch <= 1'b0;
            result      <= '0;
            dnpc        <= '0;
            mdata       <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin // idle cycles keep the last result
                jump_branch <= ex_jump_branch;
                result      <= ex_result;
                dnpc        <= ex_dnpc;
                mdata       <= ex_mdata;
            end
        end
    end

endmodule

// ==== verif/ex_top_checker.sv ====
module ex_top_checker import exu_pkg::*; (
    input logic            clk,
    input logic            rst_n,
    input logic            in_valid,
    input logic [31:0]     inst,
    input logic            out_valid,
    input logic            jump_branch,
    input logic [xlen-1:0] dnpc
);

    // output stage held quiet in reset
    a_reset_quiet: assert property (@(negedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid |=> out_valid)
        else $error("valid input without an output one cycle later");

    a_no_extra_valid: assert property (@(posedge clk) disable iff (!rst_n)
        !in_valid |=> !out_valid)
        else $error("out_valid without a valid input one cycle earlier");

    // jalr target is halfword aligned
    a_jalr_target: assert property (@(posedge clk) disable iff (!rst_n)
        (in_valid && inst[6:0] == op_jalr) |=> (jump_branch && !dnpc[0]))
        else $error("jalr gave no jump or an odd target");

endmodule

bind ex_top ex_top_checker u_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .inst        (inst),
    .out_valid   (out_valid),
    .jump_branch (jump_branch),
    .dnpc        (dnpc)
);

// ==== verif/ex_top_tb.sv ====
module ex_top_tb import exu_pkg::*; ();

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic [31:0]     inst;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] rs1_data;
    logic [xlen-1:0] rs2_data;
    logic            out_valid;
    logic            jump_branch;
    logic [xlen-1:0] result;
    logic [xlen-1:0] dnpc;
    logic [xlen-1:0] mdata;

    logic [31:0]     lfsr_state;
    logic            in_valid_q;
    logic [63:0]     q_res[$];
    logic [63:0]     q_dnpc[$];
    logic [63:0]     q_mdata[$];
    logic            q_jb[$];
    logic            q_chk[$];
    logic [63:0]     m_res;
    logic [63:0]     m_dnpc;
    logic [63:0]     m_mdata;
    logic            m_jb;
    logic            m_chk;
    int              cur_checks;
    int              cur_errors;
    int              total_checks;
    int              total_errors;
    int              n_tests;

    ex_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .inst        (inst),
        .pc          (pc),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .out_valid   (out_valid),
        .jump_branch (jump_branch),
        .result      (result),
        .dnpc        (dnpc),
        .mdata       (mdata)
    );

    always #20 clk = ~clk;

    // ==============================
    // random source and stimulus
    // ==============================
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] make_inst(input int kind);
        inst_t      w;
        logic [2:0] f3;
        logic [1:0] sel;
        w   = 32'(take_bits(32)); // registers and immediates stay random
        f3  = 3'(take_bits(3));
        sel = 2'(take_bits(2));
        case (kind)
            0: begin
                w.r.opcode = op_reg;
                w.r.funct3 = f3;
                w.r.funct7 = ((f3 == 3'b000 || f3 == 3'b101) && sel[0]) ? 7'h20 : 7'h00;
            end
            1: begin
                w.i.opcode = op_imm;
                w.i.funct3 = f3;
                if (f3 == 3'b001)
                    w.i.imm[11:6] = 6'h00;
                if (f3 == 3'b101)
                    w.i.imm[11:6] = sel[0] ? 6'h10 : 6'h00; // srai / srli
            end
            2: begin
                if (sel[1]) begin
                    w.i.opcode = op_imm32;
                    w.i.funct3 = 3'b000;
                end else begin
                    w.r.opcode = op_reg32;
                    w.r.funct3 = 3'b000;
                    w.r.funct7 = sel[0] ? 7'h20 : 7'h00;
                end
            end
            3: begin
                w.b.opcode = op_branch;
                w.b.funct3 = f3[1] ? (f3 | 3'b100) : f3; // skip 010 and 011
            end
            4: begin
                case (sel)
                    2'd0:    w.j.opcode = op_jal;
                    2'd1: begin
                        w.i.opcode = op_jalr;
                        w.i.funct3 = 3'b000;
                    end
                    2'd2:    w.u.opcode = op_lui;
                    default: w.u.opcode = op_auipc;
                endcase
            end
            default: begin
                w.r.opcode = sel[0] ? op_store : op_load;
            end
        endcase
        return w;
    endfunction

    // ==============================
    // reference model
    // ==============================
    task automatic model(input logic [31:0] ins, input logic [63:0] p, a, b,
                         output logic [63:0] res, npc, output logic jb, chk);
        logic [63:0] imm_i;
        logic [63:0] imm_s;
        logic [63:0] imm_b;
        logic [63:0] imm_u;
        logic [63:0] imm_j;
        logic [63:0] y;
        logic [63:0] sum;
        logic [5:0]  sh;
        logic        f7b5;
        imm_i = {{52{ins[31]}}, ins[31:20]};
        imm_s = {{52{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{52{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
        imm_j = {{44{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        f7b5  = ins[30];
        res   = a;
        npc   = p + 64'd4;
        jb    = 1'b0;
        chk   = 1'b1;
        case (ins[6:0])
            op_reg, op_imm: begin
                y  = (ins[6:0] == op_reg) ? b : imm_i;
                sh = y[5:0];
                case (ins[14:12])
                    3'b000: res = (ins[6:0] == op_reg && f7b5) ? a - y : a + y;
                    3'b001: res = a << sh;
                    3'b010: res = {63'd0, $signed(a) < $signed(y)};
                    3'b011: res = {63'd0, a < y};
                    3'b100: res = a ^ y;
                    3'b101: begin
                        if (f7b5)
                            res = $signed(a) >>> sh;
                        else
                            res = a >> sh;
                    end
                    3'b110: res = a | y;
                    default: res = a & y;
                endcase
            end
            op_imm32, op_reg32: begin
                if (ins[6:0] == op_imm32)
                    sum = a + imm_i;
                else
                    sum = f7b5 ? a - b : a + b;
                res = {{32{sum[31]}}, sum[31:0]};
            end
            op_branch: begin
                chk = 1'b0; // result not defined for branches
                case (ins[14:12])
                    3'b000: jb = (a == b);
                    3'b001: jb = (a != b);
                    3'b100: jb = ($signed(a) < $signed(b));
                    3'b101: jb = ($signed(a) >= $signed(b));
                    3'b110: jb = (a < b);
                    default: jb = (a >= b);
                endcase
                npc = jb ? p + imm_b : p + 64'd4;
            end
            op_jal: begin
                res = p + 64'd4;
                npc = p + imm_j;
                jb  = 1'b1;
            end
            op_jalr: begin
                res = p + 64'd4;
                npc = (a + imm_i) & ~64'd1;
                jb  = 1'b1;
            end
            op_lui:   res = imm_u;
            op_auipc: res = p + imm_u;
            op_load:  res = a + imm_i;
            default:  res = a + imm_s; // store
        endcase
    endtask

    task automatic compare_value(input string name, input logic [63:0] exp, got);
        cur_checks++;
        if (got !== exp) begin
            cur_errors++;
            $display("Fail t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic issue(input int kind);
        logic [31:0] w;
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] p;
        logic [63:0] e_res;
        logic [63:0] e_dnpc;
        logic        e_jb;
        logic        e_chk;
        w = make_inst(kind);
        a = take_bits(64);
        b = take_bits(64);
        p = take_bits(62) << 2;
        if (w[6:0] == op_branch && take_bits(2) == 0)
            b = a; // equal operands
        model(w, p, a, b, e_res, e_dnpc, e_jb, e_chk);
        @(posedge clk);
        #2;
        in_valid = 1'b1;
        inst     = w;
        pc       = p;
        rs1_data = a;
        rs2_data = b;
        q_res.push_back(e_res);
        q_dnpc.push_back(e_dnpc);
        q_jb.push_back(e_jb);
        q_chk.push_back(e_chk);
        q_mdata.push_back(b);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #2;
            in_valid = 1'b0;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle(1);
        while (q_res.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (q_res.size() != 0) begin
            $display("timeout: %0d results never came out of the DUT", q_res.size());
            $display("Result: FAILED");
            $finish;
        end else begin
            @(negedge clk);
        end
    endtask

    task automatic run_test(input int kind, input int n, input bit gaps);
        int k;
        for (int i = 0; i < n; i++) begin
            k = (kind < 0) ? int'(take_bits(3) % 6) : kind;
            issue(k);
            if (gaps)
                idle(int'(take_bits(2)));
        end
        drain();
    endtask

    task automatic end_test(input string name);
        $display("test %-14s %0d checks, %0d errors", name, cur_checks, cur_errors);
        total_checks += cur_checks;
        total_errors += cur_errors;
        n_tests++;
        cur_checks = 0;
        cur_errors = 0;
    endtask

    // ==============================
    // output monitor
    // ==============================
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            in_valid_q <= 1'b0;
        else
            in_valid_q <= in_valid;
    end

    always @(negedge clk) begin
        if (rst_n) begin
            compare_value("out_valid", in_valid_q, out_valid);
            if (out_valid === 1'b1 && q_res.size() == 0) begin
                cur_errors++;
                $display("out_valid high at t=%0t with no instruction in flight", $time);
            end else if (out_valid === 1'b1) begin
                m_res   = q_res.pop_front();
                m_dnpc  = q_dnpc.pop_front();
                m_jb    = q_jb.pop_front();
                m_chk   = q_chk.pop_front();
                m_mdata = q_mdata.pop_front();
                if (m_chk)
                    compare_value("result", m_res, result);
                compare_value("dnpc", m_dnpc, dnpc);
                compare_value("jump_branch", m_jb, jump_branch);
                compare_value("mdata", m_mdata, mdata);
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        in_valid     = 1'b0;
        inst         = '0;
        pc           = '0;
        rs1_data     = '0;
        rs2_data     = '0;
        lfsr_state   = 32'hb235;
        cur_checks   = 0;
        cur_errors   = 0;
        total_checks = 0;
        total_errors = 0;
        n_tests      = 0;

        repeat (8) begin
            @(negedge clk);
            compare_value("out_valid", 1'b0, out_valid);
            compare_value("jump_branch", 1'b0, jump_branch);
        end
        @(posedge clk);
        #2;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("result", 64'd0, result);
        compare_value("dnpc", 64'd0, dnpc);
        compare_value("mdata", 64'd0, mdata);

        run_test(-1, 40, 1'b1); // mixed stream, idle gaps
        end_test("reset_latency");
        run_test(0, 60, 1'b0);
        run_test(1, 60, 1'b0);
        end_test("alu");
        run_test(2, 40, 1'b0);
        end_test("word_ops");
        run_test(3, 60, 1'b0);
        end_test("branches");
        run_test(4, 40, 1'b0);
        end_test("jump_upper");
        run_test(5, 40, 1'b0);
        end_test("load_store");

        $display("%0d tests, %0d checks, %0d errors", n_tests, total_checks, total_errors);
        if (total_errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== rv_exu.f ====
source/exu_pkg.sv
source/idu.sv
source/alu.sv
source/bcu.sv
source/exu.sv
source/ex_top.sv
verif/ex_top_checker.sv
verif/ex_top_tb.sv

// ==== Bender.yml ====
package:
  name: rv_exu

sources:
  - files:
      - source/exu_pkg.sv
      - source/idu.sv
      - source/alu.sv
      - source/bcu.sv
      - source/exu.sv
      - source/ex_top.sv
  - target: test
    files:
      - verif/ex_top_checker.sv
      - verif/ex_top_tb.sv
